// File: common/backplane_pkg.sv
// Backplane front end shared definitions
// Slot and bus sizes, sequencer step period, plugin classes,
// sequencer states and the physical pin assignment tables

package backplane_pkg;

	localparam int nr_slots         = 12;
	localparam int slot_io_width    = 6;
	localparam int led_width        = 8;
	localparam int diob_width       = 128;
	localparam int pin_base         = 16;	// Physical pin of vector bit 0
	localparam int ledb_step_cycles = 128;	// Roughly 1 MHz step rate

	typedef logic [3:0] slot_nr_t;
	typedef logic [7:0] type_id_t;

	localparam type_id_t type_id_none = 8'hFF;	// Pulled-up bus, no cardlet

	typedef enum logic [2:0] {
		class_empty       = 3'd0,
		class_5in1out     = 3'd1,
		class_in          = 3'd2,
		class_inverted_in = 3'd3,
		class_lwl_in      = 3'd4,
		class_out         = 3'd5
	} plugin_class_t;

	typedef enum logic [2:0] {
		st_start      = 3'd0,
		st_id_prepare = 3'd1,
		st_id_read    = 3'd2,
		st_str1_set   = 3'd3,
		st_str1_clear = 3'd4,
		st_str2_set   = 3'd5,
		st_str2_clear = 3'd6,
		st_loop       = 3'd7
	} ledb_state_t;

	// Physical pin numbers, index is the slot number
	localparam int slot_mode_pin [nr_slots] = '{
		68, 90, 85, 95, 65, 113, 47, 131, 18, 136, 36, 118
	};

	// Strobe 1 then strobe 2
	localparam int slot_str_pin [nr_slots][2] = '{
		'{ 64,  66}, '{104, 106}, '{ 81,  83}, '{ 97,  99},
		'{ 67,  51}, '{115, 117}, '{ 49,  33}, '{133, 135},
		'{ 16,  32}, '{134, 132}, '{ 34,  50}, '{116, 114}
	};

	// General I/O lines 0 to 5 of each slot
	localparam int slot_io_pin [nr_slots][slot_io_width] = '{
		'{ 58,  52,  60,  54,  62,  56},	// Slot 0
		'{ 98,  92, 100,  94, 102,  96},
		'{ 75,  69,  77,  71,  79,  73},
		'{ 89, 105,  91, 103,  93, 101},
		'{ 59,  57,  61,  55,  63,  53},	// Slot 4
		'{107, 123, 109, 121, 111, 119},
		'{ 41,  39,  43,  37,  45,  35},
		'{125, 141, 127, 139, 129, 137},
		'{ 24,  26,  22,  28,  20,  30},	// Slot 8
		'{142, 126, 140, 128, 138, 130},
		'{ 42,  44,  40,  46,  38,  48},
		'{124, 108, 122, 110, 120, 112}
	};

	localparam int oe_pin [2] = '{86, 88};

	// LED/ID bus bit 0 first
	localparam int ledb_pin [led_width] = '{84, 82, 80, 78, 76, 74, 72, 70};

endpackage

// File: common/ledb_bus_if.sv
// LED/ID bus interface
// Slot control lines and the shared bus between the sequencer
// and the pin mapper; the mapper returns the sampled bus pins

`timescale 1ns/100ps

interface ledb_bus_if;
	import backplane_pkg::*;

	logic [nr_slots-1:0]       mode;	// Low selects ID readout
	logic [nr_slots-1:0][1:0]  str;	// LED latch strobes
	logic [1:0]                oe;	// Shared output enables
	logic [led_width-1:0]      ledb_out;
	logic                      ledb_drive;	// High drives all bus pins
	logic [led_width-1:0]      ledb_in;

	modport sequencer (
		output mode,
		output str,
		output oe,
		output ledb_out,
		output ledb_drive,
		input  ledb_in
	);

	modport mapper (
		input  mode,
		input  str,
		input  oe,
		input  ledb_out,
		input  ledb_drive,
		output ledb_in
	);

endinterface

// File: source/cardlet_type_decoder.sv
// Cardlet type decoder
// Maps each slot's type ID to its plugin class and flags IDs that
// match no known cardlet; any unknown ID raises the overall error

`timescale 1ns/100ps

module cardlet_type_decoder (
	input  backplane_pkg::type_id_t      [backplane_pkg::nr_slots-1:0] cardlet_types,
	output backplane_pkg::plugin_class_t [backplane_pkg::nr_slots-1:0] cardlet_classes,
	output logic [backplane_pkg::nr_slots-1:0] unknown_type,
	output logic plugin_error
);
	import backplane_pkg::*;

	always_comb
	begin
		for (int s = 0; s < nr_slots; s++)
		begin
			unknown_type[s] = 1'b0;
			case (cardlet_types[s])
				type_id_none:
					cardlet_classes[s] = class_empty;
				8'h01, 8'h02:	// LWL and LEMO I/O
					cardlet_classes[s] = class_5in1out;
				8'h07, 8'h09:	// Digital and opto inputs
					cardlet_classes[s] = class_in;
				8'h03:
					cardlet_classes[s] = class_inverted_in;
				8'h04:
					cardlet_classes[s] = class_lwl_in;
				8'h05, 8'h06, 8'h08:	// LWL, LEMO and SSR outputs
					cardlet_classes[s] = class_out;
				default:
				begin
					cardlet_classes[s] = class_empty;	// Treated as empty slot
					unknown_type[s]    = 1'b1;
				end
			endcase
		end
	end

	assign plugin_error = |unknown_type;

endmodule

// File: source/pin_mapper.sv
// Pin mapper
// Places slot control lines, shared enables, the LED/ID bus and the
// slot I/O lines onto the digital I/O pins and returns the inputs

`timescale 1ns/100ps

module pin_mapper (
	ledb_bus_if.mapper bus,

	input  logic [backplane_pkg::diob_width-1:0] diob_in,
	output logic [backplane_pkg::diob_width-1:0] diob_out,
	output logic [backplane_pkg::diob_width-1:0] diob_dir,

	input  logic [backplane_pkg::nr_slots*backplane_pkg::slot_io_width-1:0] slot_out,
	input  logic [backplane_pkg::nr_slots*backplane_pkg::slot_io_width-1:0] slot_dir,
	output logic [backplane_pkg::nr_slots*backplane_pkg::slot_io_width-1:0] slot_in
);
	import backplane_pkg::*;

	always_comb
	begin
		// Pins without a function stay inputs driving 0
		diob_out    = '0;
		diob_dir    = '0;
		slot_in     = '0;
		bus.ledb_in = '0;

		for (int s = 0; s < nr_slots; s++)
		begin
			diob_out[slot_mode_pin[s] - pin_base] = bus.mode[s];
			diob_dir[slot_mode_pin[s] - pin_base] = 1'b1;

			for (int k = 0; k < 2; k++)
			begin
				diob_out[slot_str_pin[s][k] - pin_base] = bus.str[s][k];
				diob_dir[slot_str_pin[s][k] - pin_base] = 1'b1;
			end

			for (int k = 0; k < slot_io_width; k++)
			begin
				diob_out[slot_io_pin[s][k] - pin_base] = slot_out[s*slot_io_width + k];
				diob_dir[slot_io_pin[s][k] - pin_base] = slot_dir[s*slot_io_width + k];
				slot_in[s*slot_io_width + k]           = diob_in[slot_io_pin[s][k] - pin_base];
			end
		end

		for (int k = 0; k < 2; k++)
		begin
			diob_out[oe_pin[k] - pin_base] = bus.oe[k];
			diob_dir[oe_pin[k] - pin_base] = 1'b1;
		end

		// Shared bus turns around as a whole
		for (int b = 0; b < led_width; b++)
		begin
			diob_out[ledb_pin[b] - pin_base] = bus.ledb_out[b];
			diob_dir[ledb_pin[b] - pin_base] = bus.ledb_drive;
			bus.ledb_in[b]                   = diob_in[ledb_pin[b] - pin_base];
		end
	end

endmodule

// File: ledb_sequencer/ledb_sequencer.sv
// LED/ID bus sequencer
// Visits one slot at a time at the prescaler rate: precharges the
// shared bus, reads the cardlet type ID with the mode line low, then
// latches the two inverted LED patterns with their strobes

`timescale 1ns/100ps

module ledb_sequencer (
	input  logic clock,
	input  logic reset,

	ledb_bus_if.sequencer bus,

	input  logic [backplane_pkg::nr_slots-1:0][backplane_pkg::led_width-1:0] slot_led1,
	input  logic [backplane_pkg::nr_slots-1:0][backplane_pkg::led_width-1:0] slot_led2,

	output backplane_pkg::type_id_t [backplane_pkg::nr_slots-1:0] cardlet_types
);
	import backplane_pkg::*;

	logic [$clog2(ledb_step_cycles)-1:0] prescaler;
	ledb_state_t state;
	slot_nr_t    slot;	// Slot currently served
	logic        step;

	assign step = (prescaler == '0);

	// Output enables are held asserted (active low on the cardlets)
	assign bus.oe = '0;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			prescaler      <= $bits(prescaler)'(ledb_step_cycles - 1);
			state          <= st_start;
			slot           <= slot_nr_t'(nr_slots - 1);	// First loop step wraps to 0
			cardlet_types  <= {nr_slots{type_id_none}};
			bus.mode       <= '1;
			bus.str        <= '1;	// Both strobes high to clear the LEDs
			bus.ledb_out   <= '0;
			bus.ledb_drive <= 1'b1;
		end
		else
		begin
			if (step)
				prescaler <= $bits(prescaler)'(ledb_step_cycles - 1);
			else
				prescaler <= prescaler - 1'b1;

			if (step)
			begin
				case (state)
					st_start:
					begin
						bus.str <= '0;	// End of LED initialisation
						state   <= st_loop;
					end

					st_loop:
					begin
						if (slot == slot_nr_t'(nr_slots - 1))
							slot <= '0;
						else
							slot <= slot + 1'b1;
						bus.ledb_out   <= '1;	// Precharge
						bus.ledb_drive <= 1'b1;
						state          <= st_id_prepare;
					end

					st_id_prepare:
					begin
						bus.ledb_drive <= 1'b0;	// Cardlet takes the bus
						bus.mode[slot] <= 1'b0;
						state          <= st_id_read;
					end

					st_id_read:
					begin
						cardlet_types[slot] <= bus.ledb_in;
						bus.mode[slot]      <= 1'b1;
						state               <= st_str1_set;
					end

					st_str1_set:
					begin
						bus.ledb_drive <= 1'b1;
						bus.ledb_out   <= ~slot_led1[slot];	// LEDs are active low
						bus.str[slot]  <= 2'b01;
						state          <= st_str1_clear;
					end

					st_str1_clear:
					begin
						bus.str[slot] <= 2'b00;
						state         <= st_str2_set;
					end

					st_str2_set:
					begin
						bus.ledb_drive <= 1'b1;
						bus.ledb_out   <= ~slot_led2[slot];
						bus.str[slot]  <= 2'b10;
						state          <= st_str2_clear;
					end

					st_str2_clear:
					begin
						bus.str[slot] <= 2'b00;
						state         <= st_loop;
					end

					default:
						state <= st_start;
				endcase
			end
		end
	end

endmodule

// File: source/backplane_top.sv
// Backplane front end top level
// Connects the LED/ID bus sequencer, the cardlet type decoder and
// the pin mapper onto the 128-pin digital I/O port

`timescale 1ns/100ps

module backplane_top (
	input  logic clock,
	input  logic reset,

	// Digital I/O port
	input  logic [backplane_pkg::diob_width-1:0] diob_in,
	output logic [backplane_pkg::diob_width-1:0] diob_out,
	output logic [backplane_pkg::diob_width-1:0] diob_dir,

	// Per-slot I/O lines, six per slot
	input  logic [backplane_pkg::nr_slots*backplane_pkg::slot_io_width-1:0] slot_out,
	input  logic [backplane_pkg::nr_slots*backplane_pkg::slot_io_width-1:0] slot_dir,
	output logic [backplane_pkg::nr_slots*backplane_pkg::slot_io_width-1:0] slot_in,

	// LED patterns, eight bits per slot
	input  logic [backplane_pkg::nr_slots*backplane_pkg::led_width-1:0] slot_led1,
	input  logic [backplane_pkg::nr_slots*backplane_pkg::led_width-1:0] slot_led2,

	// Status
	output logic [backplane_pkg::nr_slots*8-1:0] cardlet_types,
	output logic [backplane_pkg::nr_slots*3-1:0] cardlet_classes,
	output logic [backplane_pkg::nr_slots-1:0]   unknown_type,
	output logic                                 plugin_error
);

	ledb_bus_if ledb_bus ();

	// Walks the slots, reads IDs and strobes LED patterns
	ledb_sequencer i_ledb_sequencer (
		.clock         (clock),
		.reset         (reset),
		.bus           (ledb_bus.sequencer),
		.slot_led1     (slot_led1),
		.slot_led2     (slot_led2),
		.cardlet_types (cardlet_types)
	);

	cardlet_type_decoder i_cardlet_type_decoder (
		.cardlet_types   (cardlet_types),
		.cardlet_classes (cardlet_classes),
		.unknown_type    (unknown_type),
		.plugin_error    (plugin_error)
	);

	pin_mapper i_pin_mapper (
		.bus      (ledb_bus.mapper),
		.diob_in  (diob_in),
		.diob_out (diob_out),
		.diob_dir (diob_dir),
		.slot_out (slot_out),
		.slot_dir (slot_dir),
		.slot_in  (slot_in)
	);

endmodule

// File: tests/tb_backplane.sv
// Backplane front end testbench
// Directed checks of the reset state, the pin mapping, the ID readout
// and class decode, unknown IDs and the LED strobes, with a behavioral
// cardlet model answering on the shared bus pins

`timescale 1ns/100ps

module tb_backplane;
	import backplane_pkg::*;

	localparam int clock_period = 8;
	localparam int pass_timeout = 12000;	// Clocks for one pass over all slots
	localparam int first_pin    = 16;

	// Backplane wiring in physical pin numbers
	localparam int mode_pins [nr_slots] = '{68, 90, 85, 95, 65, 113, 47, 131, 18, 136, 36, 118};
	localparam int str_pins [nr_slots][2] = '{
		'{64, 66}, '{104, 106}, '{81, 83}, '{97, 99}, '{67, 51}, '{115, 117},
		'{49, 33}, '{133, 135}, '{16, 32}, '{134, 132}, '{34, 50}, '{116, 114}
	};
	localparam int io_pins [nr_slots][6] = '{
		'{58, 52, 60, 54, 62, 56}, '{98, 92, 100, 94, 102, 96},
		'{75, 69, 77, 71, 79, 73}, '{89, 105, 91, 103, 93, 101},
		'{59, 57, 61, 55, 63, 53}, '{107, 123, 109, 121, 111, 119},
		'{41, 39, 43, 37, 45, 35}, '{125, 141, 127, 139, 129, 137},
		'{24, 26, 22, 28, 20, 30}, '{142, 126, 140, 128, 138, 130},
		'{42, 44, 40, 46, 38, 48}, '{124, 108, 122, 110, 120, 112}
	};
	localparam int oe_pins [2] = '{86, 88};
	localparam int bus_pins [8] = '{84, 82, 80, 78, 76, 74, 72, 70};
	localparam logic [7:0] known_ids [nr_slots] = '{
		8'h01, 8'h03, 8'h04, 8'h05, 8'h07, 8'h09, 8'hFF, 8'h02, 8'h06, 8'h08, 8'hFF, 8'h03
	};

	logic         clock;
	logic         reset;
	logic [127:0] diob_in;
	logic [127:0] diob_out;
	logic [127:0] diob_dir;
	logic [127:0] diob_base;	// Pin inputs apart from the bus
	logic [71:0]  slot_out;
	logic [71:0]  slot_dir;
	logic [71:0]  slot_in;
	logic [95:0]  slot_led1;
	logic [95:0]  slot_led2;
	logic [95:0]  cardlet_types;
	logic [35:0]  cardlet_classes;
	logic [11:0]  unknown_type;
	logic         plugin_error;
	logic [7:0]   slot_ids [nr_slots];	// IDs the cardlets answer with
	int           str1_count [nr_slots];
	int           str2_count [nr_slots];
	int           seed;
	int           error_count;
	int           timeout_count;

	backplane_top i_backplane_top (
		.clock           (clock),
		.reset           (reset),
		.diob_in         (diob_in),
		.diob_out        (diob_out),
		.diob_dir        (diob_dir),
		.slot_out        (slot_out),
		.slot_dir        (slot_dir),
		.slot_in         (slot_in),
		.slot_led1       (slot_led1),
		.slot_led2       (slot_led2),
		.cardlet_types   (cardlet_types),
		.cardlet_classes (cardlet_classes),
		.unknown_type    (unknown_type),
		.plugin_error    (plugin_error)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	function automatic int pin_index(input int pin);
		return pin - first_pin;
	endfunction

	function automatic logic [7:0] bus_bits(input logic [127:0] pins);
		logic [7:0] value;
		for (int b = 0; b < 8; b++)
			value[b] = pins[pin_index(bus_pins[b])];
		return value;
	endfunction

	function automatic logic [95:0] random96();
		return {$random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic plugin_class_t expected_class(input logic [7:0] id);
		case (id)
			8'hFF:               return class_empty;
			8'h01, 8'h02:        return class_5in1out;
			8'h07, 8'h09:        return class_in;
			8'h03:               return class_inverted_in;
			8'h04:               return class_lwl_in;
			8'h05, 8'h06, 8'h08: return class_out;
			default:             return class_empty;
		endcase
	endfunction

	// Selected cardlet drives its ID once the design releases the bus
	function automatic logic [127:0] cardlet_bus(input logic [127:0] base,
			input logic [127:0] pins_out, input logic [127:0] pins_dir);
		logic [127:0] pins;
		logic [7:0]   value;
		pins  = base;
		value = 8'hFF;	// Pull-ups
		for (int s = 0; s < nr_slots; s++)
		begin
			if (!pins_out[pin_index(mode_pins[s])] && bus_bits(pins_dir) == 8'h00)
				value = slot_ids[s];
		end
		for (int b = 0; b < 8; b++)
			pins[pin_index(bus_pins[b])] = value[b];
		return pins;
	endfunction

	always_comb
		diob_in = cardlet_bus(diob_base, diob_out, diob_dir);

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] expected);
		error_count++;
		$display("Error: %s got %0h expected %0h", name, got, expected);
	endtask

	// Returns at the falling edge after the last slot's ID readout
	task automatic wait_pass_end(output bit ok);
		int cycles;
		bit seen_low;
		cycles   = 0;
		seen_low = 1'b0;
		ok       = 1'b0;
		while (!ok && cycles < pass_timeout)
		begin
			@(negedge clock);
			cycles++;
			if (!diob_out[pin_index(mode_pins[nr_slots-1])])
				seen_low = 1'b1;
			else if (seen_low)
				ok = 1'b1;
		end
		if (!ok)
		begin
			timeout_count++;
			$display("Timeout: the sequencer did not finish a pass within %0d cycles",
				pass_timeout);
		end
	endtask

	task automatic check_bus_drive(input int s, input int strobe, input logic [7:0] pattern);
		if (bus_bits(diob_dir) !== 8'hFF)
			report_mismatch($sformatf("diob_dir bus pins, slot %0d strobe %0d", s, strobe),
				128'(bus_bits(diob_dir)), 128'(8'hFF));
		if (bus_bits(diob_out) !== ~pattern)
			report_mismatch($sformatf("diob_out bus pins, slot %0d strobe %0d", s, strobe),
				128'(bus_bits(diob_out)), 128'(~pattern));
	endtask

	// Runs for the whole simulation once started
	task automatic watch_strobes();
		logic        s1;
		logic        s2;
		logic        any_high;
		logic        active;
		logic [11:0] prev1;
		logic [11:0] prev2;
		active = 1'b0;	// Strobes all high until the first step
		prev1  = '1;
		prev2  = '1;
		for (int s = 0; s < nr_slots; s++)
		begin
			str1_count[s] = 0;
			str2_count[s] = 0;
		end
		forever
		begin
			@(negedge clock);
			any_high = 1'b0;
			for (int s = 0; s < nr_slots; s++)
			begin
				s1       = diob_out[pin_index(str_pins[s][0])];
				s2       = diob_out[pin_index(str_pins[s][1])];
				any_high = any_high | s1 | s2;
				if (active && s1 && s2)
				begin
					error_count++;
					$display("Slot %0d has both LED strobes high at once", s);
				end
				if (active && s1)
					check_bus_drive(s, 1, slot_led1[s*8 +: 8]);
				if (active && s2)
					check_bus_drive(s, 2, slot_led2[s*8 +: 8]);
				if (active && s1 && !prev1[s])
					str1_count[s]++;
				if (active && s2 && !prev2[s])
					str2_count[s]++;
				prev1[s] = s1;
				prev2[s] = s2;
			end
			if (!any_high)
				active = 1'b1;
		end
	endtask

	task automatic check_reset_state();
		int i;
		@(negedge clock);
		for (int s = 0; s < nr_slots; s++)
		begin
			i = pin_index(mode_pins[s]);
			if (diob_out[i] !== 1'b1)
				report_mismatch($sformatf("diob_out[%0d]", i), 128'(diob_out[i]), 128'(1'b1));
			if (diob_dir[i] !== 1'b1)
				report_mismatch($sformatf("diob_dir[%0d]", i), 128'(diob_dir[i]), 128'(1'b1));
			for (int k = 0; k < 2; k++)
			begin
				i = pin_index(str_pins[s][k]);
				if (diob_out[i] !== 1'b1)
					report_mismatch($sformatf("diob_out[%0d]", i), 128'(diob_out[i]), 128'(1'b1));
				if (diob_dir[i] !== 1'b1)
					report_mismatch($sformatf("diob_dir[%0d]", i), 128'(diob_dir[i]), 128'(1'b1));
			end
		end
		for (int k = 0; k < 2; k++)
		begin
			i = pin_index(oe_pins[k]);
			if (diob_out[i] !== 1'b0)
				report_mismatch($sformatf("diob_out[%0d]", i), 128'(diob_out[i]), 128'(1'b0));
			if (diob_dir[i] !== 1'b1)
				report_mismatch($sformatf("diob_dir[%0d]", i), 128'(diob_dir[i]), 128'(1'b1));
		end
		if (bus_bits(diob_dir) !== 8'hFF)
			report_mismatch("diob_dir bus pins", 128'(bus_bits(diob_dir)), 128'(8'hFF));
		if (bus_bits(diob_out) !== 8'h00)
			report_mismatch("diob_out bus pins", 128'(bus_bits(diob_out)), 128'(8'h00));
		if (cardlet_types !== {12{8'hFF}})
			report_mismatch("cardlet_types", 128'(cardlet_types), 128'({12{8'hFF}}));
		if (unknown_type !== 12'h000)
			report_mismatch("unknown_type", 128'(unknown_type), 128'(12'h000));
		if (plugin_error !== 1'b0)
			report_mismatch("plugin_error", 128'(plugin_error), 128'(1'b0));
	endtask

	task automatic check_pin_mapping();
		logic [95:0] r;
		int i;
		int n;
		r         = random96();
		slot_out  = r[71:0];
		r         = random96();
		slot_dir  = r[71:0];
		diob_base = {random96(), $random(seed)};
		@(negedge clock);
		for (int s = 0; s < nr_slots; s++)
		begin
			for (int k = 0; k < 6; k++)
			begin
				i = pin_index(io_pins[s][k]);
				n = s * 6 + k;
				if (diob_out[i] !== slot_out[n])
					report_mismatch($sformatf("diob_out[%0d]", i), 128'(diob_out[i]), 128'(slot_out[n]));
				if (diob_dir[i] !== slot_dir[n])
					report_mismatch($sformatf("diob_dir[%0d]", i), 128'(diob_dir[i]), 128'(slot_dir[n]));
				if (slot_in[n] !== diob_base[i])
					report_mismatch($sformatf("slot_in[%0d]", n), 128'(slot_in[n]), 128'(diob_base[i]));
			end
		end
	endtask

	task automatic check_id_readout();
		int rot;
		bit ok;
		rot = {$random(seed)} % nr_slots;
		for (int s = 0; s < nr_slots; s++)
			slot_ids[s] = known_ids[(s + rot) % nr_slots];
		wait_pass_end(ok);
		for (int s = 0; ok && s < nr_slots; s++)
		begin
			if (cardlet_types[s*8 +: 8] !== slot_ids[s])
				report_mismatch($sformatf("cardlet_types slot %0d", s),
					128'(cardlet_types[s*8 +: 8]), 128'(slot_ids[s]));
			if (cardlet_classes[s*3 +: 3] !== expected_class(slot_ids[s]))
				report_mismatch($sformatf("cardlet_classes slot %0d", s),
					128'(cardlet_classes[s*3 +: 3]), 128'(expected_class(slot_ids[s])));
		end
	endtask

	task automatic check_unknown_id();
		int slot;
		bit ok;
		slot           = {$random(seed)} % nr_slots;
		slot_ids[slot] = 8'h2A;
		wait_pass_end(ok);
		if (ok && unknown_type !== (12'(1) << slot))
			report_mismatch("unknown_type", 128'(unknown_type), 128'(12'(1) << slot));
		if (ok && cardlet_classes[slot*3 +: 3] !== class_empty)
			report_mismatch("cardlet_classes", 128'(cardlet_classes[slot*3 +: 3]), 128'(class_empty));
		if (ok && plugin_error !== 1'b1)
			report_mismatch("plugin_error", 128'(plugin_error), 128'(1'b1));
		slot_ids[slot] = 8'h06;	// Known output cardlet
		wait_pass_end(ok);
		if (ok && unknown_type !== 12'h000)
			report_mismatch("unknown_type", 128'(unknown_type), 128'(12'h000));
		if (ok && cardlet_classes[slot*3 +: 3] !== class_out)
			report_mismatch("cardlet_classes", 128'(cardlet_classes[slot*3 +: 3]), 128'(class_out));
		if (ok && plugin_error !== 1'b0)
			report_mismatch("plugin_error", 128'(plugin_error), 128'(1'b0));
	endtask

	task automatic check_led_strobes();
		int before1 [nr_slots];
		int before2 [nr_slots];
		bit ok;
		slot_led1 = random96();
		slot_led2 = random96();
		before1   = str1_count;
		before2   = str2_count;
		wait_pass_end(ok);
		for (int s = 0; ok && s < nr_slots; s++)
		begin
			if (str1_count[s] == before1[s] || str2_count[s] == before2[s])
			begin
				error_count++;
				$display("Slot %0d did not strobe both LED patterns during one pass", s);
			end
		end
	endtask

	initial
	begin
		seed          = 7542;
		error_count   = 0;
		timeout_count = 0;
		reset         = 1'b1;
		diob_base     = '1;
		slot_out      = '0;
		slot_dir      = '0;
		slot_led1     = random96();
		slot_led2     = random96();
		for (int s = 0; s < nr_slots; s++)
			slot_ids[s] = 8'hFF;
		repeat (2) @(negedge clock);
		reset = 1'b0;

		fork
			watch_strobes();
		join_none

		check_reset_state();
		check_pin_mapping();
		check_id_readout();
		check_unknown_id();
		check_led_strobes();

		$display("Value errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: flist.f
common/backplane_pkg.sv
common/ledb_bus_if.sv
source/cardlet_type_decoder.sv
source/pin_mapper.sv
ledb_sequencer/ledb_sequencer.sv
source/backplane_top.sv
tests/tb_backplane.sv

// File: run.sh
#!/bin/sh
# Builds the backplane testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_backplane -f flist.f -o tb_backplane
./obj_dir/tb_backplane | tee sim.log

if grep -qx "Testbench passed" sim.log
then
	exit 0
fi
exit 1
